// File: verilog/spi_xike_consts.svh
`ifndef SPI_XIKE_CONSTS_SVH
`define SPI_XIKE_CONSTS_SVH

// Sample and tag widths
`define SAMPLE_W        16
`define MUA_W           17
`define STREAM_W        4
`define CHAN_W          6
`define NUM_STREAMS     2
`define NUM_CHANNELS    32

// FIFO depths must be powers of two
`define RAW_FIFO_DEPTH  16
`define HOST_FIFO_DEPTH 64

// Host register bus
`define REG_ADDR_W      5
`define REG_DATA_W      16
`define ADDR_RUN        5'd0
`define ADDR_SCLK_DIV   5'd1
`define ADDR_FILTER_EN  5'd2
`define ADDR_OVF_CLEAR  5'd3
`define ADDR_STATUS     5'd16
`define ADDR_FRAME_CNT  5'd17

// SPI framing
`define FRAME_BITS      16
`define CS_HIGH_HALVES  2
`define PIPE_FRAMES     2

`endif

// File: verilog/acq_pkg.sv
package acq_pkg;

  `include "spi_xike_consts.svh"

  // Where a sample came from
  typedef struct packed {
    logic [`STREAM_W-1:0] stream;
    logic [`CHAN_W-1:0]   chan;
  } sample_tag_t;

  // One amplifier sample as it leaves the SPI master
  typedef struct packed {
    sample_tag_t          tag;
    logic [`SAMPLE_W-1:0] data;
  } raw_sample_t;

  // Host word, stream sits at bits 26 to 23
  typedef struct packed {
    logic [4:0]               pad;
    logic [`STREAM_W-1:0]     stream;
    logic [`CHAN_W-1:0]       chan;
    logic signed [`MUA_W-1:0] value;
  } mua_word_t;

endpackage

// File: verilog/reg_pkg.sv
package reg_pkg;

  `include "spi_xike_consts.svh"

  // One host register access, write and read strobes are exclusive
  typedef struct packed {
    logic                   wr;
    logic                   rd;
    logic [`REG_ADDR_W-1:0] addr;
    logic [`REG_DATA_W-1:0] wdata;
  } reg_req_t;

  // Settings shared by the SPI master and the filter
  typedef struct packed {
    logic       run;
    logic [7:0] sclk_div;
    logic       filter_en;
  } ctrl_t;

endpackage

// File: verilog/acq_regs.sv
`timescale 1ns/1ns
`include "spi_xike_consts.svh"

module acq_regs (
  input  logic                   bus_clk,
  input  logic                   rst_n,
  input  reg_pkg::reg_req_t      req,
  output logic [`REG_DATA_W-1:0] rdata,
  output reg_pkg::ctrl_t         ctrl,
  input  logic                   frame_done,
  input  logic                   drop,
  input  logic                   spi_running,
  output logic                   overflow
);

  logic [`REG_DATA_W-1:0] frame_cnt;
  logic [`REG_DATA_W-1:0] rd_mux;
  logic                   wr_run;
  logic                   run_rise;

  assign wr_run   = req.wr && (req.addr == `ADDR_RUN);
  assign run_rise = wr_run && req.wdata[0] && !ctrl.run;

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl      <= '0;
      overflow  <= 1'b0;
      frame_cnt <= '0;
    end else begin
      if (wr_run)
        ctrl.run <= req.wdata[0];
      if (req.wr && (req.addr == `ADDR_SCLK_DIV))
        ctrl.sclk_div <= req.wdata[7:0];
      if (req.wr && (req.addr == `ADDR_FILTER_EN))
        ctrl.filter_en <= req.wdata[0];

      // A drop in the clearing cycle keeps the flag set
      if (drop)
        overflow <= 1'b1;
      else if (req.wr && (req.addr == `ADDR_OVF_CLEAR) && req.wdata[0])
        overflow <= 1'b0;

      // Count restarts with every new acquisition run
      if (run_rise)
        frame_cnt <= '0;
      else if (frame_done)
        frame_cnt <= frame_cnt + 1'b1;
    end
  end

  always_comb begin
    rd_mux = '0;
    case (req.addr)
      `ADDR_RUN:       rd_mux[0]   = ctrl.run;
      `ADDR_SCLK_DIV:  rd_mux[7:0] = ctrl.sclk_div;
      `ADDR_FILTER_EN: rd_mux[0]   = ctrl.filter_en;
      `ADDR_STATUS:    rd_mux[1:0] = {overflow, spi_running};
      `ADDR_FRAME_CNT: rd_mux      = frame_cnt;
      default:         rd_mux      = '0;
    endcase
  end

  // Read data holds until the next read strobe
  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n)
      rdata <= '0;
    else if (req.rd)
      rdata <= rd_mux;
  end

  // Host issues one access per cycle
  assert property (@(posedge bus_clk) disable iff (!rst_n) !(req.wr && req.rd))
    else $error("register read and write in the same cycle");

endmodule

// File: verilog/intan_spi_master.sv
`timescale 1ns/1ns
`include "spi_xike_consts.svh"

module intan_spi_master (
  input  logic                 bus_clk,
  input  logic                 rst_n,
  input  reg_pkg::ctrl_t       ctrl,
  input  logic                 miso_c1,
  input  logic                 miso_c2,
  output logic                 sclk,
  output logic                 cs,
  output logic                 mosi,
  output acq_pkg::raw_sample_t sample,
  output logic                 sample_wr,
  output logic                 frame_done,
  output logic                 spi_running
);

  localparam int CS_LOW_HALVES = 2 * `FRAME_BITS;
  localparam int LAST_HALF     = CS_LOW_HALVES + `CS_HIGH_HALVES - 1;
  localparam int HALF_W        = $clog2(LAST_HALF + 1);
  localparam int WARM_W        = $clog2(`PIPE_FRAMES + 1);

  logic [7:0]                           div_cnt;
  logic [7:0]                           half_len;
  logic                                 half_end;
  logic [HALF_W-1:0]                    half_idx;
  logic                                 rise_edge;
  logic                                 fall_edge;
  logic                                 last_rise;
  logic                                 frame_end;
  logic [`CHAN_W-1:0]                   cur_chan;
  logic [`CHAN_W-1:0]                   next_chan;
  logic [`PIPE_FRAMES-1:0][`CHAN_W-1:0] chan_hist;
  logic [WARM_W-1:0]                    warm_cnt;
  logic [`SAMPLE_W-1:0]                 mosi_sr;
  logic [`SAMPLE_W-1:0]                 miso_sr1;
  logic [`SAMPLE_W-1:0]                 miso_sr2;
  logic                                 push_s1;

  // CONVERT command, channel in bits 13..8
  function automatic logic [`SAMPLE_W-1:0] convert_cmd(input logic [`CHAN_W-1:0] chan);
    convert_cmd = {{(`SAMPLE_W - `CHAN_W - 8){1'b0}}, chan, 8'h00};
  endfunction

  // Divider values below 2 run at 2
  assign half_len  = (ctrl.sclk_div < 8'd2) ? 8'd2 : ctrl.sclk_div;
  assign half_end  = spi_running && (div_cnt >= half_len - 8'd1);
  assign rise_edge = half_end && (half_idx < CS_LOW_HALVES) && !half_idx[0];
  assign fall_edge = half_end && (half_idx < CS_LOW_HALVES) && half_idx[0];
  assign last_rise = rise_edge && (half_idx == CS_LOW_HALVES - 2);
  assign frame_end = half_end && (half_idx == LAST_HALF);
  assign next_chan = (cur_chan == `NUM_CHANNELS - 1) ? '0 : cur_chan + 1'b1;
  assign mosi      = mosi_sr[`SAMPLE_W-1];

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      spi_running <= 1'b0;
      cs          <= 1'b1;
      sclk        <= 1'b0;
      div_cnt     <= '0;
      half_idx    <= '0;
      cur_chan    <= '0;
      warm_cnt    <= '0;
      mosi_sr     <= '0;
      frame_done  <= 1'b0;
      sample_wr   <= 1'b0;
      push_s1     <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      sample_wr  <= push_s1;
      push_s1    <= 1'b0;
      if (!spi_running) begin
        if (ctrl.run) begin
          spi_running <= 1'b1;
          cs          <= 1'b0;
          div_cnt     <= '0;
          half_idx    <= '0;
          cur_chan    <= '0;
          warm_cnt    <= '0;
          mosi_sr     <= convert_cmd('0);
        end
      end else if (!half_end) begin
        div_cnt <= div_cnt + 1'b1;
      end else begin
        div_cnt <= '0;
        if (frame_end) begin
          frame_done <= 1'b1;
          cur_chan   <= next_chan;
          if (warm_cnt != `PIPE_FRAMES)
            warm_cnt <= warm_cnt + 1'b1;
          // Run low lets the frame finish and parks with CS high
          if (ctrl.run) begin
            half_idx <= '0;
            cs       <= 1'b0;
            mosi_sr  <= convert_cmd(next_chan);
          end else begin
            spi_running <= 1'b0;
          end
        end else begin
          half_idx <= half_idx + 1'b1;
          if (rise_edge) begin
            sclk <= 1'b1;
            if (last_rise && (warm_cnt == `PIPE_FRAMES)) begin
              sample_wr <= 1'b1;
              push_s1   <= 1'b1;
            end
          end else if (fall_edge) begin
            sclk    <= 1'b0;
            mosi_sr <= {mosi_sr[`SAMPLE_W-2:0], 1'b0};
            if (half_idx == CS_LOW_HALVES - 1)
              cs <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (rise_edge) begin
      miso_sr1 <= {miso_sr1[`SAMPLE_W-2:0], miso_c1};
      miso_sr2 <= {miso_sr2[`SAMPLE_W-2:0], miso_c2};
    end
    // Stream 0 goes out first and stream 1 follows one cycle later
    if (last_rise) begin
      sample.tag.stream <= '0;
      sample.tag.chan   <= chan_hist[`PIPE_FRAMES-1];
      sample.data       <= {miso_sr1[`SAMPLE_W-2:0], miso_c1};
    end else if (push_s1) begin
      sample.tag.stream <= sample.tag.stream + 1'b1;
      sample.data       <= miso_sr2;
    end
    // Results return PIPE_FRAMES frames after their command
    if (frame_end)
      chan_hist <= {chan_hist[`PIPE_FRAMES-2:0], cur_chan};
  end

  assert property (@(posedge bus_clk) disable iff (!rst_n) !spi_running |-> cs && !sclk)
    else $error("SPI bus active while master is idle");

endmodule

// File: verilog/sample_fifo.sv
`timescale 1ns/1ns

module sample_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 16
) (
  input  logic     bus_clk,
  input  logic     rst_n,
  input  logic     clear,
  input  payload_t din,
  input  logic     wr,
  input  logic     rd,
  output payload_t dout,
  output logic     empty,
  output logic     full,
  output logic     drop
);

  localparam int AW = $clog2(DEPTH);

  payload_t      mem [DEPTH];
  logic [AW:0]   wr_ptr;
  logic [AW:0]   rd_ptr;
  logic          do_wr;
  logic          do_rd;

  // Extra pointer bit tells full from empty
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign do_wr = wr && !full && !clear;
  assign do_rd = rd && !empty && !clear;
  assign drop  = wr && full && !clear;

  // Head word is visible before the read strobe
  assign dout = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (do_wr)
      mem[wr_ptr[AW-1:0]] <= din;
  end

  // Readers must look at empty before popping
  assert property (@(posedge bus_clk) disable iff (!rst_n) rd |-> !empty)
    else $error("FIFO read while empty");

endmodule

// File: verilog/mua_filter.sv
`timescale 1ns/1ns
`include "spi_xike_consts.svh"

module mua_filter (
  input  logic                 bus_clk,
  input  logic                 rst_n,
  input  logic                 filter_en,
  input  acq_pkg::raw_sample_t din,
  input  logic                 din_valid,
  output acq_pkg::mua_word_t   dout,
  output logic                 dout_valid
);

  import acq_pkg::*;

  localparam int HIST_N = `NUM_STREAMS * `NUM_CHANNELS;
  localparam int HIST_W = $clog2(HIST_N);

  logic [`SAMPLE_W-1:0]     hist [HIST_N];
  raw_sample_t              s1_sample;
  logic [`SAMPLE_W-1:0]     s1_prev;
  logic                     s1_valid;
  logic signed [`MUA_W-1:0] diff;

  // One history slot per stream and channel
  function automatic logic [HIST_W-1:0] hist_index(input sample_tag_t tag);
    hist_index = HIST_W'(tag.stream * `NUM_CHANNELS + tag.chan);
  endfunction

  assign diff = $signed({1'b0, s1_sample.data}) - $signed({1'b0, s1_prev});

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid   <= 1'b0;
      dout_valid <= 1'b0;
      for (int i = 0; i < HIST_N; i++)
        hist[i] <= '0;
    end else begin
      s1_valid   <= din_valid;
      dout_valid <= s1_valid;
      // History follows the raw sample whether or not filtering is on
      if (s1_valid)
        hist[hist_index(s1_sample.tag)] <= s1_sample.data;
    end
  end

  always_ff @(posedge bus_clk) begin
    s1_sample <= din;
    s1_prev   <= hist[hist_index(din.tag)];

    dout.pad    <= '0;
    dout.stream <= s1_sample.tag.stream;
    dout.chan   <= s1_sample.tag.chan;
    if (filter_en)
      dout.value <= diff;
    else
      dout.value <= {1'b0, s1_sample.data};
  end

  // Read of a slot in the cycle it is written back would see stale history
  assert property (@(posedge bus_clk) disable iff (!rst_n)
                   din_valid && s1_valid |-> din.tag != s1_sample.tag)
    else $error("back-to-back samples for the same stream and channel");

endmodule

// File: verilog/spi_xike.sv
`timescale 1ns/1ns
`include "spi_xike_consts.svh"

module spi_xike (
  input  logic                   bus_clk,
  input  logic                   rst_n,
  input  reg_pkg::reg_req_t      reg_req,
  output logic [`REG_DATA_W-1:0] reg_rdata,
  input  logic                   miso_c1,
  input  logic                   miso_c2,
  output logic                   sclk,
  output logic                   cs,
  output logic                   mosi,
  input  logic                   host_open,
  input  logic                   host_rden,
  output acq_pkg::mua_word_t     host_data,
  output logic                   host_empty,
  output logic                   overflow,
  output logic                   spi_running
);

  import acq_pkg::*;
  import reg_pkg::*;

  ctrl_t       ctrl;
  raw_sample_t raw_sample;
  logic        raw_wr;
  raw_sample_t raw_head;
  logic        raw_empty;
  logic        frame_done;
  mua_word_t   mua_word;
  logic        mua_valid;
  logic        host_drop;

  acq_regs acq_regs_i (
    .bus_clk     (bus_clk    ),
    .rst_n       (rst_n      ),
    .req         (reg_req    ),
    .rdata       (reg_rdata  ),
    .ctrl        (ctrl       ),
    .frame_done  (frame_done ),
    .drop        (host_drop  ),
    .spi_running (spi_running),
    .overflow    (overflow   )
  );

  intan_spi_master spi_master_i (
    .bus_clk     (bus_clk    ),
    .rst_n       (rst_n      ),
    .ctrl        (ctrl       ),
    .miso_c1     (miso_c1    ),
    .miso_c2     (miso_c2    ),
    .sclk        (sclk       ),
    .cs          (cs         ),
    .mosi        (mosi       ),
    .sample      (raw_sample ),
    .sample_wr   (raw_wr     ),
    .frame_done  (frame_done ),
    .spi_running (spi_running)
  );

  // Filter drains the raw FIFO as soon as a sample lands
  sample_fifo #(
    .payload_t (raw_sample_t   ),
    .DEPTH     (`RAW_FIFO_DEPTH)
  ) raw_fifo_i (
    .bus_clk (bus_clk   ),
    .rst_n   (rst_n     ),
    .clear   (1'b0      ),
    .din     (raw_sample),
    .wr      (raw_wr    ),
    .rd      (!raw_empty),
    .dout    (raw_head  ),
    .empty   (raw_empty ),
    .full    (          ),
    .drop    (          )
  );

  mua_filter mua_filter_i (
    .bus_clk    (bus_clk         ),
    .rst_n      (rst_n           ),
    .filter_en  (ctrl.filter_en  ),
    .din        (raw_head        ),
    .din_valid  (!raw_empty      ),
    .dout       (mua_word        ),
    .dout_valid (mua_valid       )
  );

  // Host FIFO stays empty while the host side is closed
  sample_fifo #(
    .payload_t (mua_word_t      ),
    .DEPTH     (`HOST_FIFO_DEPTH)
  ) host_fifo_i (
    .bus_clk (bus_clk   ),
    .rst_n   (rst_n     ),
    .clear   (!host_open),
    .din     (mua_word  ),
    .wr      (mua_valid ),
    .rd      (host_rden ),
    .dout    (host_data ),
    .empty   (host_empty),
    .full    (          ),
    .drop    (host_drop )
  );

endmodule

// File: tb/tb_spi_xike.sv
`timescale 1ns/1ns
`include "spi_xike_consts.svh"

module tb_spi_xike;

  import acq_pkg::*;
  import reg_pkg::*;

  logic                   bus_clk = 1'b0;
  logic                   rst_n;
  reg_req_t               reg_req;
  logic [`REG_DATA_W-1:0] reg_rdata;
  logic                   miso_c1;
  logic                   miso_c2;
  logic                   sclk;
  logic                   cs;
  logic                   mosi;
  logic                   host_open;
  logic                   host_rden;
  mua_word_t              host_data;
  logic                   host_empty;
  logic                   overflow;
  logic                   spi_running;

  logic [15:0]        tdata [20];
  logic [15:0]        hist_m [`NUM_STREAMS * `NUM_CHANNELS];
  logic [31:0]        exp_q [$];
  logic [`CHAN_W-1:0] chan_q [$];
  logic [31:0]        head_word;
  logic [16:0]        lfsr;
  logic [15:0]        word_c1;
  logic [15:0]        word_c2;
  logic [15:0]        cmd_sr;
  logic               prev_sclk;
  logic               prev_cs;
  logic               loaded;
  logic               filt_on;
  int                 bit_idx;
  int                 rise_cnt;
  int                 cmd_chan;
  int                 pair_idx;
  int                 frames_in_run;
  int                 drops_exp;
  int                 read_quota;
  int                 frame_cycles;

  always #20 bus_clk = ~bus_clk;

  spi_xike dut_i (
    .bus_clk     (bus_clk    ),
    .rst_n       (rst_n      ),
    .reg_req     (reg_req    ),
    .reg_rdata   (reg_rdata  ),
    .miso_c1     (miso_c1    ),
    .miso_c2     (miso_c2    ),
    .sclk        (sclk       ),
    .cs          (cs         ),
    .mosi        (mosi       ),
    .host_open   (host_open  ),
    .host_rden   (host_rden  ),
    .host_data   (host_data  ),
    .host_empty  (host_empty ),
    .overflow    (overflow   ),
    .spi_running (spi_running)
  );

  // x^17 + x^14 + 1
  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    lfsr_next = {s[15:0], s[16] ^ s[13]};
  endfunction

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERR time %0t ns %s got %h expected %h", $time, name, got, exp);
    abort_run();
  endtask

  task automatic report_problem(input string what);
    $display("Failure at %0t ns: %s", $time, what);
    abort_run();
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else report_mismatch(name, got, exp);
  endtask

  task automatic reg_write(input logic [4:0] addr, input logic [15:0] data);
    @(negedge bus_clk);
    reg_req.wr    = 1'b1;
    reg_req.addr  = addr;
    reg_req.wdata = data;
    @(negedge bus_clk);
    reg_req.wr = 1'b0;
  endtask

  task automatic reg_read(input logic [4:0] addr, input logic [15:0] exp, input string name);
    @(negedge bus_clk);
    reg_req.rd   = 1'b1;
    reg_req.addr = addr;
    @(negedge bus_clk);
    reg_req.rd = 1'b0;
    assert (reg_rdata === exp) else report_mismatch(name, reg_rdata, exp);
  endtask

  // Next word pair for the amplifier, file words first
  task automatic load_words();
    if (pair_idx < 8) begin
      word_c1 = tdata[4 + 2 * pair_idx];
      word_c2 = tdata[5 + 2 * pair_idx];
    end else begin
      for (int i = 0; i < 32; i++) begin
        lfsr = lfsr_next(lfsr);
        if (i < 16)
          word_c1 = {word_c1[14:0], lfsr[0]};
        else
          word_c2 = {word_c2[14:0], lfsr[0]};
      end
    end
    pair_idx++;
    bit_idx = 15;
    miso_c1 = word_c1[15];
    miso_c2 = word_c2[15];
    loaded  = 1'b1;
  endtask

  // Host word the DUT must deliver, or a drop when the host FIFO is full
  task automatic expect_word(input int stream, input logic [`CHAN_W-1:0] chan,
                             input logic [15:0] data);
    int          slot;
    logic [16:0] value;
    slot = stream * `NUM_CHANNELS + chan;
    if (filt_on)
      value = {1'b0, data} - {1'b0, hist_m[slot]};
    else
      value = {1'b0, data};
    hist_m[slot] = data;
    if (exp_q.size() >= `HOST_FIFO_DEPTH)
      drops_exp++;
    else
      exp_q.push_back({5'b0, 4'(stream), chan, value});
  endtask

  task automatic sclk_rose();
    logic [`CHAN_W-1:0] tag;
    cmd_sr = {cmd_sr[14:0], mosi};
    rise_cnt++;
    if (rise_cnt == `FRAME_BITS) begin
      assert (cmd_sr == 16'(cmd_chan << 8))
        else report_mismatch("mosi command", cmd_sr, cmd_chan << 8);
      chan_q.push_back(cmd_sr[13:8]);
      cmd_chan = (cmd_chan == `NUM_CHANNELS - 1) ? 0 : cmd_chan + 1;
      // Result of a frame belongs to the command two frames back
      if (chan_q.size() > `PIPE_FRAMES) begin
        tag = chan_q.pop_front();
        expect_word(0, tag, word_c1);
        expect_word(1, tag, word_c2);
      end
    end
  endtask

  // Amplifier model
  always @(negedge bus_clk) begin
    if (!rst_n) begin
      prev_sclk = 1'b0;
      prev_cs   = 1'b1;
      loaded    = 1'b0;
    end else begin
      if (cs && !prev_cs) begin
        assert (rise_cnt == `FRAME_BITS)
          else report_mismatch("sclk rising edges in frame", rise_cnt, `FRAME_BITS);
        frames_in_run++;
      end
      if (!cs && prev_cs)
        rise_cnt = 0;
      if (sclk && !prev_sclk)
        sclk_rose();
      if (!sclk && prev_sclk && bit_idx > 0) begin
        bit_idx--;
        miso_c1 = word_c1[bit_idx];
        miso_c2 = word_c2[bit_idx];
      end
      if (!cs)
        loaded = 1'b0;
      else if (!loaded)
        load_words();
      prev_sclk = sclk;
      prev_cs   = cs;
    end
  end

  // Host model, read_quota below zero means no limit
  always @(negedge bus_clk) begin
    host_rden = 1'b0;
    if (rst_n && host_open && !host_empty && read_quota != 0) begin
      assert (exp_q.size() != 0) else report_problem("host word arrived with none expected");
      head_word = exp_q.pop_front();
      assert (host_data === head_word) else report_mismatch("host_data", host_data, head_word);
      host_rden = 1'b1;
      if (read_quota > 0)
        read_quota--;
    end
  end

  task automatic run_frames(input int n);
    chan_q.delete();
    cmd_chan      = 0;
    frames_in_run = 0;
    reg_write(`ADDR_RUN, 16'd1);
    reg_read(`ADDR_RUN, 16'd1, "run");
    reg_read(`ADDR_STATUS, {14'd0, drops_exp != 0, 1'b1}, "status");
    while (frames_in_run < n)
      @(negedge bus_clk);
    reg_write(`ADDR_RUN, 16'd0);
    while (spi_running)
      @(negedge bus_clk);
    repeat (frame_cycles) begin
      @(negedge bus_clk);
      check_bit("cs", cs, 1'b1);
      check_bit("sclk", sclk, 1'b0);
    end
    reg_read(`ADDR_FRAME_CNT, 16'(n), "frame_cnt");
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0)
      @(negedge bus_clk);
    @(negedge bus_clk);
    assert (host_empty === 1'b1) else report_mismatch("host_empty", host_empty, 1);
    check_bit("overflow", overflow, drops_exp != 0);
  endtask

  initial begin
    longint limit_ns;
    #1;
    limit_ns = longint'(tdata[1]) + tdata[2] + tdata[3];
    limit_ns = (limit_ns * frame_cycles * 2 + 16) * 40;
    #(limit_ns);
    report_problem("watchdog timeout, acquisition did not finish");
  end

  initial begin
    $readmemh("tb/spi_xike_testdata.txt", tdata);
    rst_n      = 1'b0;
    reg_req    = '0;
    miso_c1    = 1'b0;
    miso_c2    = 1'b0;
    host_open  = 1'b1;
    host_rden  = 1'b0;
    filt_on    = 1'b0;
    read_quota = -1;
    drops_exp  = 0;
    rise_cnt   = 0;
    bit_idx    = 0;
    pair_idx   = 0;
    lfsr       = 17'd69451;
    for (int i = 0; i < `NUM_STREAMS * `NUM_CHANNELS; i++)
      hist_m[i] = '0;
    frame_cycles = (2 * `FRAME_BITS + `CS_HIGH_HALVES) * ((tdata[0] < 2) ? 2 : tdata[0]);
    repeat (16) @(negedge bus_clk);
    rst_n = 1'b1;

    @(negedge bus_clk);
    check_bit("cs", cs, 1'b1);
    check_bit("sclk", sclk, 1'b0);
    check_bit("mosi", mosi, 1'b0);
    check_bit("host_empty", host_empty, 1'b1);
    check_bit("overflow", overflow, 1'b0);
    check_bit("spi_running", spi_running, 1'b0);
    reg_read(`ADDR_RUN, 16'd0, "run");
    reg_read(`ADDR_SCLK_DIV, 16'd0, "sclk_div");
    reg_read(`ADDR_FILTER_EN, 16'd0, "filter_en");
    reg_read(`ADDR_OVF_CLEAR, 16'd0, "ovf_clear");
    reg_read(`ADDR_STATUS, 16'd0, "status");
    reg_read(`ADDR_FRAME_CNT, 16'd0, "frame_cnt");
    reg_write(`ADDR_SCLK_DIV, tdata[0]);
    reg_read(`ADDR_SCLK_DIV, {8'd0, tdata[0][7:0]}, "sclk_div");
    reg_write(`ADDR_FILTER_EN, 16'd1);
    reg_read(`ADDR_FILTER_EN, 16'd1, "filter_en");
    reg_write(`ADDR_FILTER_EN, 16'd0);

    // Raw samples, then first differences across the channel wrap
    run_frames(tdata[1]);
    wait_drained();
    reg_write(`ADDR_FILTER_EN, 16'd1);
    filt_on = 1'b1;
    run_frames(tdata[2]);
    wait_drained();

    // Host stalled until the FIFO overflows
    read_quota = 0;
    run_frames(tdata[3]);
    check_bit("overflow", overflow, drops_exp != 0);
    reg_read(`ADDR_STATUS, {14'd0, drops_exp != 0, 1'b0}, "status");
    reg_write(`ADDR_OVF_CLEAR, 16'd1);
    drops_exp = 0;
    reg_read(`ADDR_STATUS, 16'd0, "status");
    read_quota = `HOST_FIFO_DEPTH - 1;
    while (read_quota != 0)
      @(negedge bus_clk);
    @(negedge bus_clk);
    // Last kept word still waits at the head
    check_bit("host_empty", host_empty, 1'b0);
    assert (host_data === exp_q[0]) else report_mismatch("host_data", host_data, exp_q[0]);
    host_open = 1'b0;
    @(negedge bus_clk);
    assert (host_empty === 1'b1) else report_mismatch("host_empty", host_empty, 1);
    exp_q.delete();
    host_open  = 1'b1;
    read_quota = -1;
    repeat (4) @(negedge bus_clk);

    if (host_empty === 1'b1) begin
      $display("Done: no errors");
      $finish;
    end else
      report_problem("host words left over at the end");
  end

endmodule

// File: spi_xike.f
+incdir+verilog
verilog/acq_pkg.sv
verilog/reg_pkg.sv
verilog/acq_regs.sv
verilog/intan_spi_master.sv
verilog/sample_fifo.sv
verilog/mua_filter.sv
verilog/spi_xike.sv
tb/tb_spi_xike.sv

// File: tb/spi_xike_testdata.txt
// Settings: sclk_div, frames with filter off, frames with filter on, frames for overflow
// Then 8 MISO word pairs, one pair per line: stream 0 word, stream 1 word

// Settings
0003
000c
0028
0028

// Directed MISO words, LFSR words follow after these
1234 8001
00ff ff00
7fff 0000
ffff 0001
8000 7ffe
0a5a a5a5
5555 aaaa
0000 ffff
